/* logic/bitsyncPkg.sv */
/*
 * Datapath widths and types for the symbol synchronizer.
 * Imported by every module that carries samples, timing errors,
 * accumulators or the frequency word.
 */

package bitsyncPkg;

    //**************************************************************************
    // Sample path
    //**************************************************************************
    localparam int sampleWidth = 18;

    typedef logic signed [sampleWidth-1:0] sampleT;

    // Timing error shares the sample scaling
    typedef logic signed [sampleWidth-1:0] errorT;

    //**************************************************************************
    // Lock detector and loop
    //**************************************************************************
    localparam int accWidth = 22;

    typedef logic [accWidth-1:0] accT;
    typedef logic [31:0] freqT;
    typedef logic [15:0] lockCountT;

endpackage

/* logic/bitsyncCfgPkg.sv */
/*
 * Loop and detector constants of the symbol synchronizer.
 * Averaging length, transition hold, lock threshold, loop gains and
 * the nominal sample frequency word.
 */

package bitsyncCfgPkg;

    // Valid transitions averaged per lock test
    localparam int avgLength = 16;

    // Symbols that transitionsDetected holds after the last transition
    localparam logic [7:0] holdCount = 8'd255;

    // Good tests to lock, also the bound for loss of lock
    localparam logic [15:0] lockCount = 16'd4;

    // Loop filter gains as left shifts of the rounded error
    localparam int propShift = 10;
    localparam int intShift = 4;

    localparam logic [31:0] nominalFreq = 32'h4000_0000;

endpackage

/* logic/timingErrorIf.sv */
/*
 * Per-symbol error results from the timing error detector.
 * The detector drives every signal; the lock detector only reads them.
 * errorValid marks the on-time sampleEn that carries a fresh result.
 */

`timescale 1ns/1ns

interface timingErrorIf
    import bitsyncPkg::*;
();

    logic   errorValid;
    logic   transition;
    errorT  timingError;
    sampleT slipError;

    modport detector (
        output errorValid, transition, timingError, slipError
    );

    modport monitor (
        input errorValid, transition, timingError, slipError
    );

endinterface

/* logic/sampleFrontEnd.sv */
/*
 * Sample front end for two-samples-per-symbol baseband input.
 * Averages each sample with the one before it, then shifts the result
 * through three stages that give the late, off-time and early taps.
 */

`timescale 1ns/1ns

module sampleFrontEnd
    import bitsyncPkg::*;
(
    input  logic   sampleClk,
    input  logic   sampleEn,
    input  sampleT sampleIn,
    output sampleT early,
    output sampleT offTime,
    output sampleT late
);

    sampleT sampleDelay;
    logic signed [sampleWidth:0] sampleSum;
    sampleT shiftReg [3];

    // One extra bit so the sum cannot wrap
    assign sampleSum = sampleWidth'(sampleDelay) + sampleIn;

    //**************************************************************************
    // Two sample sum and tap shift register
    //**************************************************************************
    always_ff @(posedge sampleClk) begin
        if (sampleEn) begin
            sampleDelay <= sampleIn;
            shiftReg[0] <= sampleSum[sampleWidth:1];
            shiftReg[1] <= shiftReg[0];
            shiftReg[2] <= shiftReg[1];
        end
    end

    // Newest stage is the late tap
    assign late = shiftReg[0];
    assign offTime = shiftReg[1];
    assign early = shiftReg[2];

endmodule

/* logic/timingErrorDetector.sv */
/*
 * Early/late sign-transition timing error detector.
 * Tracks the on-time/off-time phase, measures timing and slip errors at
 * each data transition, holds the transition flag and recovers the data.
 */

`timescale 1ns/1ns

module timingErrorDetector
    import bitsyncPkg::*;
    import bitsyncCfgPkg::*;
(
    input  logic   sampleClk,
    input  logic   reset,
    input  logic   sampleEn,
    input  sampleT early,
    input  sampleT offTime,
    input  sampleT late,
    input  logic   slip,
    timingErrorIf.detector errBus,
    output errorT  timingError,
    output logic   errorValid,
    output logic   symEn,
    output logic   bitData,
    output sampleT symData,
    output logic   transitionsDetected,
    output sampleT dcError
);

    typedef enum logic {onTimePhase, offTimePhase} phaseT;

    phaseT      phase;
    logic       held;
    logic       transitionReg;
    errorT      timingErrorReg;
    sampleT     slipErrorReg;
    logic [7:0] holdCounter;
    logic       earlyHigh;
    logic       signChange;

    assign earlyHigh = !early[sampleWidth-1];
    assign signChange = early[sampleWidth-1] != late[sampleWidth-1];

    // The extra on-time cycle of a slip is not a symbol
    assign symEn = sampleEn && (phase == onTimePhase) && !held;
    assign errorValid = symEn;
    assign timingError = timingErrorReg;

    assign errBus.errorValid = symEn;
    assign errBus.transition = transitionReg;
    assign errBus.timingError = timingErrorReg;
    assign errBus.slipError = slipErrorReg;

    //**************************************************************************
    // Phase state and transition measurement
    //**************************************************************************
    always_ff @(posedge sampleClk) begin
        if (reset) begin
            phase <= onTimePhase;
            held <= 1'b0;
            transitionReg <= 1'b0;
            timingErrorReg <= '0;
            holdCounter <= '0;
            transitionsDetected <= 1'b0;
        end else if (sampleEn) begin
            held <= 1'b0;
            if (phase == onTimePhase) begin
                // Slip stays on-time for one extra sample
                if (slip && !held) begin
                    held <= 1'b1;
                end else begin
                    phase <= offTimePhase;
                end
            end else begin
                phase <= onTimePhase;
                transitionReg <= signChange;
                if (signChange) begin
                    holdCounter <= holdCount;
                    transitionsDetected <= 1'b1;
                    // High to low keeps the off-time sign
                    timingErrorReg <= earlyHigh ? offTime : -offTime;
                end else begin
                    timingErrorReg <= '0;
                    if (holdCounter != '0) begin
                        holdCounter <= holdCounter - 1'b1;
                    end else begin
                        transitionsDetected <= 1'b0;
                    end
                end
            end
        end
    end

    // Levels captured with the transition
    always_ff @(posedge sampleClk) begin
        if (sampleEn && phase == offTimePhase) begin
            slipErrorReg <= earlyHigh ? early : late;
            dcError <= signChange ? early : '0;
        end
    end

    // Recovered data, positive sample gives a one
    always_ff @(posedge sampleClk) begin
        if (symEn) begin
            bitData <= !offTime[sampleWidth-1];
            symData <= offTime;
        end
    end

endmodule

/* logic/slipLockDetector.sv */
/*
 * Averaging slip and lock detector.
 * Sums timing and slip error magnitudes over a block of transitions,
 * then tests them to step the lock counter, set lock or request a slip.
 */

`timescale 1ns/1ns

module slipLockDetector
    import bitsyncPkg::*;
    import bitsyncCfgPkg::*;
(
    input  logic      sampleClk,
    input  logic      reset,
    input  logic      sampleEn,
    timingErrorIf.monitor errBus,
    output logic      slip,
    output logic      bitsyncLock,
    output lockCountT lockCounter
);

    typedef enum logic {averageState, testState} avgStateT;

    avgStateT                     state;
    logic [$clog2(avgLength)-1:0] avgCount;
    accT                          avgError;
    accT                          avgSlipError;
    logic [sampleWidth-1:0]       absError;
    logic [sampleWidth-1:0]       absSlipError;
    logic                         timingLarge;

    assign absError = errBus.timingError[sampleWidth-1] ?
                      -errBus.timingError : errBus.timingError;
    assign absSlipError = errBus.slipError[sampleWidth-1] ?
                          -errBus.slipError : errBus.slipError;

    // Timing error above half the on-time level is a bad test
    assign timingLarge = avgError > (avgSlipError >> 1);

    always_ff @(posedge sampleClk) begin
        if (reset) begin
            state <= averageState;
            avgCount <= ($clog2(avgLength))'(avgLength - 1);
            avgError <= '0;
            avgSlipError <= '0;
            lockCounter <= '0;
            bitsyncLock <= 1'b0;
            slip <= 1'b0;
        end else if (sampleEn) begin
            slip <= 1'b0;
            case (state)
                averageState: begin
                    if (errBus.errorValid && errBus.transition) begin
                        avgError <= avgError + accT'(absError);
                        avgSlipError <= avgSlipError + accT'(absSlipError);
                        if (avgCount == '0) begin
                            state <= testState;
                        end else begin
                            avgCount <= avgCount - 1'b1;
                        end
                    end
                end
                testState: begin
                    state <= averageState;
                    avgCount <= ($clog2(avgLength))'(avgLength - 1);
                    avgError <= '0;
                    avgSlipError <= '0;
                    if (timingLarge) begin
                        // Negative bound mirrors the lock threshold
                        if (lockCounter == -lockCount) begin
                            bitsyncLock <= 1'b0;
                            lockCounter <= '0;
                            slip <= 1'b1;
                        end else begin
                            lockCounter <= lockCounter - 1'b1;
                        end
                    end else if (lockCounter == lockCount) begin
                        bitsyncLock <= 1'b1;
                        lockCounter <= '0;
                    end else begin
                        lockCounter <= lockCounter + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

/* logic/loopFilter.sv */
/*
 * Proportional plus integral loop filter.
 * Turns each symbol's timing error into the sample frequency word
 * around the nominal frequency.
 */

`timescale 1ns/1ns

module loopFilter
    import bitsyncPkg::*;
    import bitsyncCfgPkg::*;
(
    input  logic  sampleClk,
    input  logic  reset,
    input  logic  errorValid,
    input  errorT timingError,
    output freqT  sampleFreq
);

    logic signed [11:0] roundedError;
    logic signed [31:0] errorExt;
    freqT               integrator;
    freqT               integratorNext;

    // Top 12 bits, rounded on the next bit down
    assign roundedError = timingError[sampleWidth-1 -: 12] + 12'(timingError[sampleWidth-13]);
    assign errorExt = 32'(roundedError);
    assign integratorNext = integrator + freqT'(errorExt <<< intShift);

    always_ff @(posedge sampleClk) begin
        if (reset) begin
            integrator <= '0;
            sampleFreq <= nominalFreq;
        end else if (errorValid) begin
            integrator <= integratorNext;
            sampleFreq <= nominalFreq + integratorNext + freqT'(errorExt <<< propShift);
        end
    end

endmodule

/* logic/bitsync.sv */
/*
 * Single-channel symbol synchronizer, top level.
 * Takes two baseband samples per symbol on sampleEn and returns the
 * recovered bits, symbol enables, lock status and sample frequency word.
 */

`timescale 1ns/1ns

module bitsync
    import bitsyncPkg::*;
(
    input  logic      sampleClk,
    input  logic      reset,
    input  logic      sampleEn,
    input  sampleT    sampleIn,
    output logic      symEn,
    output logic      sym2xEn,
    output logic      bitData,
    output sampleT    symData,
    output logic      transitionsDetected,
    output sampleT    dcError,
    output logic      bitsyncLock,
    output lockCountT lockCounter,
    output freqT      sampleFreq
);

    sampleT early;
    sampleT offTime;
    sampleT late;
    errorT  timingError;
    logic   errorValid;
    logic   slip;

    timingErrorIf errBus ();

    // Twice-per-symbol enable is the sample enable itself
    assign sym2xEn = sampleEn;

    sampleFrontEnd frontEnd (
        .sampleClk (sampleClk),
        .sampleEn  (sampleEn),
        .sampleIn  (sampleIn),
        .early     (early),
        .offTime   (offTime),
        .late      (late)
    );

    timingErrorDetector errorDetector (
        .sampleClk           (sampleClk),
        .reset               (reset),
        .sampleEn            (sampleEn),
        .early               (early),
        .offTime             (offTime),
        .late                (late),
        .slip                (slip),
        .errBus              (errBus.detector),
        .timingError         (timingError),
        .errorValid          (errorValid),
        .symEn               (symEn),
        .bitData             (bitData),
        .symData             (symData),
        .transitionsDetected (transitionsDetected),
        .dcError             (dcError)
    );

    slipLockDetector lockDetector (
        .sampleClk   (sampleClk),
        .reset       (reset),
        .sampleEn    (sampleEn),
        .errBus      (errBus.monitor),
        .slip        (slip),
        .bitsyncLock (bitsyncLock),
        .lockCounter (lockCounter)
    );

    loopFilter sampleLoop (
        .sampleClk   (sampleClk),
        .reset       (reset),
        .errorValid  (errorValid),
        .timingError (timingError),
        .sampleFreq  (sampleFreq)
    );

endmodule

/* test/bitsync_chk.sv */
/*
 * Concurrent assertions on the symbol synchronizer outputs.
 * Bound into bitsync, so every instance of the top level is checked.
 */

`timescale 1ns/1ns

module bitsync_chk (
    input logic sampleClk,
    input logic reset,
    input logic sampleEn,
    input logic symEn,
    input logic bitsyncLock
);

    // symEn seen on the last sampleEn
    logic lastEnSym;

    always_ff @(posedge sampleClk) begin
        if (reset) begin
            lastEnSym <= 1'b0;
        end else if (sampleEn) begin
            lastEnSym <= symEn;
        end
    end

    symOnlyWithEn: assert property (@(posedge sampleClk) symEn |-> sampleEn)
        else $error("symEn high without sampleEn");

    symNotBackToBack: assert property (@(posedge sampleClk) disable iff (reset)
        (sampleEn && lastEnSym) |-> !symEn)
        else $error("symEn on two consecutive sampleEn");

    lockNotInReset: assert property (@(posedge sampleClk)
        $rose(bitsyncLock) |-> !$past(reset))
        else $error("bitsyncLock rose during reset");

endmodule

bind bitsync bitsync_chk symbolChk (.*);

/* test/bitsyncTb.sv */
/*
 * Testbench for the symbol synchronizer.
 * Reads each test from the cases file, sends two samples per bit with a
 * small random offset, and checks recovery, transition hold and lock.
 */

`timescale 1ns/1ns

module bitsyncTb
    import bitsyncPkg::*;
    import bitsyncCfgPkg::*;
;

    localparam int clkPeriod = 10;
    localparam int resetCycles = 16;
    localparam int seedInit = 51;
    localparam int maxCases = 32;
    localparam string casesFile = "test/bitsyncCases.txt";

    logic sampleClk, reset, sampleEn, symEn, sym2xEn, bitData;
    logic transitionsDetected, bitsyncLock;
    sampleT sampleIn, symData, dcError;
    lockCountT lockCounter;
    freqT sampleFreq;

    logic [63:0] caseKind [maxCases];
    logic [63:0] casePattern [maxCases];
    int caseBits [maxCases], caseRepeats [maxCases], casePreamble [maxCases];
    sampleT caseAmplitude [maxCases];
    freqT caseFreq [maxCases];

    int seed, caseTotal, errors, checks, testErrors, failedTests, lockAt;
    logic sentBits [$];
    sampleT sentLevels [$];
    sampleT amplitude;
    int preamble;

    bitsync DUT (.*);

    always #(clkPeriod / 2) sampleClk = ~sampleClk;

    //**************************************************************************
    // Compare tasks
    //**************************************************************************
    task automatic reportFail();
        errors++;
        testErrors++;
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            reportFail();
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic checkSample(input string name, input sampleT expected, input sampleT actual);
        checks++;
        if (actual !== expected) begin
            reportFail();
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic checkFreq(input string name, input freqT expected, input freqT actual);
        checks++;
        if (actual !== expected) begin
            reportFail();
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkLockCount(input string name, input lockCountT expected,
                                  input lockCountT actual);
        checks++;
        if (actual !== expected) begin
            reportFail();
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    //**************************************************************************
    // Stimulus
    //**************************************************************************
    // Front end is filled with the first level while reset is high
    task automatic resetDut(input sampleT flushValue);
        @(posedge sampleClk);
        reset <= 1'b1;
        repeat (resetCycles / 2) begin
            sampleEn <= 1'b1;
            sampleIn <= flushValue;
            @(posedge sampleClk);
            sampleEn <= 1'b0;
            @(posedge sampleClk);
        end
        reset <= 1'b0;
        @(negedge sampleClk);
        checkBit("symEn", 1'b0, symEn);
        checkBit("transitionsDetected", 1'b0, transitionsDetected);
        checkBit("bitsyncLock", 1'b0, bitsyncLock);
        checkLockCount("lockCounter", '0, lockCounter);
        checkFreq("sampleFreq", nominalFreq, sampleFreq);
    endtask

    task automatic sendSample(input sampleT value, output logic symSeen);
        @(posedge sampleClk);
        sampleEn <= 1'b1;
        sampleIn <= value;
        @(negedge sampleClk);
        symSeen = symEn;
        checkBit("sym2xEn", 1'b1, sym2xEn);
        @(posedge sampleClk);
        sampleEn <= 1'b0;
        @(negedge sampleClk);
        checkBit("sym2xEn", 1'b0, sym2xEn);
    endtask

    // Symbol j sits on the sampleEn after the on-time one, so bit j-1 is out
    task automatic sendSymbol(input logic bitValue);
        int j;
        int offset;
        logic symFirst;
        logic symSecond;
        sampleT value;
        j = sentBits.size();
        offset = $random(seed) % 8;
        value = (bitValue ? amplitude : -amplitude) + sampleT'(offset);
        sentBits.push_back(bitValue);
        sentLevels.push_back(value);
        sendSample(value, symFirst);
        sendSample(value, symSecond);
        checkBit("symEn", 1'b0, symFirst);
        checkBit("symEn", 1'b1, symSecond);
        if (j - 1 >= preamble) begin
            checkBit("bitData", sentBits[j-1], bitData);
            checkSample("symData", sentLevels[j-1], symData);
        end
        if (j - 2 >= preamble) begin
            checkSample("dcError", (sentBits[j-2] != sentBits[j-1]) ?
                        sentLevels[j-2] : '0, dcError);
        end
        if (bitsyncLock && lockAt < 0) begin
            lockAt = j;
        end
    endtask

    task automatic runCase(input int n);
        logic unused;
        logic lastBit;
        int total;
        amplitude = caseAmplitude[n];
        preamble = casePreamble[n];
        total = caseBits[n] * caseRepeats[n];
        testErrors = 0;
        lockAt = -1;
        sentBits.delete();
        sentLevels.delete();
        resetDut(casePattern[n][0] ? amplitude : -amplitude);
        sendSample(casePattern[n][0] ? amplitude : -amplitude, unused);
        for (int i = 0; i < total; i++) begin
            sendSymbol(casePattern[n][i % caseBits[n]]);
        end
        lastBit = sentBits[total-1];
        if (caseKind[n] == "hold") begin
            sendSymbol(lastBit);
            checkBit("transitionsDetected", 1'b1, transitionsDetected);
            repeat (int'(holdCount) + 1) sendSymbol(lastBit);
            checkBit("transitionsDetected", 1'b0, transitionsDetected);
        end
        if (caseKind[n] == "lock") begin
            checkBit("bitsyncLock", 1'b1, bitsyncLock);
            if (lockAt >= 0 && lockAt < (int'(lockCount) + 1) * avgLength) begin
                reportFail();
                $display("bitsyncLock rose after only %0d symbols", lockAt);
            end
        end
        checkFreq("sampleFreq", caseFreq[n], sampleFreq);
        if (testErrors != 0) begin
            failedTests++;
        end
        $display("Test %0d %0s: %0s, %0d symbols", n, caseKind[n],
                 (testErrors == 0) ? "ok" : "mismatch", sentBits.size());
    endtask

    //**************************************************************************
    // Cases file, watchdog and report
    //**************************************************************************
    initial begin
        int fd;
        longint timeoutNs;
        string line;
        sampleClk = 1'b0;
        reset = 1'b1;
        sampleEn = 1'b0;
        sampleIn = '0;
        seed = seedInit;
        caseTotal = 0;
        timeoutNs = 1000;
        fd = $fopen(casesFile, "r");
        if (fd == 0) begin
            $display("Could not open the cases file");
            $display("*** FAILED ***");
            $finish;
        end else begin
            while (!$feof(fd) && caseTotal < maxCases) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 2 && line.getc(0) != "#") begin
                    void'($sscanf(line, "%s %d %h %d %h %d %h", caseKind[caseTotal],
                        caseBits[caseTotal], casePattern[caseTotal],
                        caseRepeats[caseTotal], caseAmplitude[caseTotal],
                        casePreamble[caseTotal], caseFreq[caseTotal]));
                    // Four sampleEn periods per symbol, plus reset and hold tail
                    timeoutNs += (caseBits[caseTotal] * caseRepeats[caseTotal]
                        + int'(holdCount) + 3) * 8 * clkPeriod + resetCycles * clkPeriod * 2;
                    caseTotal++;
                end
            end
            $fclose(fd);
            fork
                begin
                    #(timeoutNs);
                    $display("Run timed out before all tests finished");
                    $display("*** FAILED ***");
                    $finish;
                end
            join_none
            for (int n = 0; n < caseTotal; n++) begin
                runCase(n);
            end
            $display("Tests %0d, failing %0d, checks %0d, errors %0d",
                     caseTotal, failedTests, checks, errors);
            if (errors == 0 && caseTotal > 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule

/* bitsync.f */
logic/bitsyncPkg.sv
logic/bitsyncCfgPkg.sv
logic/timingErrorIf.sv
logic/sampleFrontEnd.sv
logic/timingErrorDetector.sv
logic/slipLockDetector.sv
logic/loopFilter.sv
logic/bitsync.sv
test/bitsync_chk.sv
test/bitsyncTb.sv

/* run.sh */
#!/bin/sh
# Compile the symbol synchronizer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module bitsyncTb \
    -f bitsync.f -o bitsyncSim

simOutput=$(./obj_dir/bitsyncSim)
echo "$simOutput"

if echo "$simOutput" | grep -qF '*** PASSED ***'; then
    exit 0
else
    exit 1
fi

/* test/bitsyncCases.txt */
# kind nBits pattern(hex, LSB sent first) repeats amplitude(hex) preamble sampleFreq(hex)
# bits checks recovery, hold adds a constant tail, lock expects bitsyncLock
bits 32 5a3c96e1 4 10000 4 40000000
bits 32 0f0f33cc 4 08000 4 40000000
bits 16 c5a7 6 1f000 3 40000000
bits 64 0123456789abcdef 2 04000 4 40000000
bits 24 ffe001 5 00400 2 40000000
bits 8 96 8 00100 2 40000000
bits 40 8000000001 3 10000 2 40000000
bits 32 deadbeef 3 02000 5 40000000
hold 16 5a5a 2 10000 4 40000000
hold 32 00ff00ff 1 06000 3 40000000
hold 8 a5 3 1c000 2 40000000
lock 32 aaaaaaaa 6 08000 4 40000000
lock 32 55555555 6 10000 4 40000000
lock 16 aaaa 12 00800 3 40000000
